// File: hps_link.f
hdl/host_link_pkg.sv
hdl/ps2_pkg.sv
hdl/host_frame.sv
hdl/host_regs.sv
hdl/file_loader.sv
hdl/ps2_kbd_tx.sv
hdl/hps_link.sv
test/clk_gen.sv
test/hps_link_checker.sv
test/hps_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= hps_link.f
TB_TOP    ?= hps_link_tb
RTL_TOP   ?= hps_link
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
LINTFLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: test/hps_link_tb.sv
module hps_link_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int conf_len   = 4;
	localparam int ps2_div    = 3;
	localparam int fifo_bits  = 3;
	localparam int n_tests    = 5;
	localparam int frame_clks = 2 * ps2_div * (ps2_pkg::ps2_frame_bits + ps2_pkg::ps2_idle_gap + 1);
	localparam int limit_clks = 16 + n_tests * 600 + (1 << fifo_bits) * frame_clks;

	logic clk_sys, rst_n, io_enable, io_strobe, status_set;
	logic [15:0] io_din, io_dout;
	logic [8*conf_len-1:0] conf_str;
	logic [31:0] joy_out [6];
	logic [31:0] status, status_in;
	logic [1:0] buttons;
	logic forced_scandoubler, ioctl_download, ioctl_wr;
	logic [7:0] ioctl_index, ioctl_dout;
	logic [24:0] ioctl_addr;
	logic ps2_kbd_clk_out, ps2_kbd_data_out;
	logic [10:0] ps2_key;

	logic [15:0] tx_q[$];
	logic [15:0] reply_q[$];
	logic [7:0]  kb_q[$];
	logic [24:0] wr_addr_q[$];
	logic [7:0]  wr_data_q[$];
	logic [7:0]  exp_ps2[$];
	logic [10:0] frame_q[$];
	logic [10:0] frame_bits;
	logic [10:0] key_model;
	int          frame_cnt;
	logic [31:0] rng;
	int          err_mismatch;
	int          err_other;

	clk_gen clk_i (.clk_sys(clk_sys), .rst_n(rst_n));

	hps_link #(
		.conf_len (conf_len),
		.ps2_div  (ps2_div),
		.fifo_bits(fifo_bits)
	) dut_i (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.io_enable(io_enable), .io_strobe(io_strobe), .io_din(io_din), .io_dout(io_dout),
		.conf_str(conf_str),
		.joystick_0(joy_out[0]), .joystick_1(joy_out[1]), .joystick_2(joy_out[2]),
		.joystick_3(joy_out[3]), .joystick_4(joy_out[4]), .joystick_5(joy_out[5]),
		.buttons(buttons), .forced_scandoubler(forced_scandoubler), .status(status),
		.status_in(status_in), .status_set(status_set),
		.ioctl_download(ioctl_download), .ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ps2_kbd_clk_out(ps2_kbd_clk_out), .ps2_kbd_data_out(ps2_kbd_data_out),
		.ps2_key(ps2_key)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			err_mismatch++;
		end
	endtask

	// one transaction, a free cycle after every strobe for the reply
	task automatic send_txn();
		reply_q.delete();
		@(posedge clk_sys) io_enable <= 1'b1;
		foreach (tx_q[i]) begin
			@(posedge clk_sys);
			io_strobe <= 1'b1;
			io_din    <= tx_q[i];
			@(posedge clk_sys) io_strobe <= 1'b0;
			@(negedge clk_sys) reply_q.push_back(io_dout);
		end
		@(posedge clk_sys) io_enable <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// download writes
	always @(negedge clk_sys) begin
		if (rst_n && ioctl_wr) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
	end

	// device frames, sampled on the falling PS/2 clock
	always @(negedge ps2_kbd_clk_out) begin
		frame_bits = {ps2_kbd_data_out, frame_bits[10:1]};
		frame_cnt++;
		if (frame_cnt == ps2_pkg::ps2_frame_bits) begin
			frame_q.push_back(frame_bits);
			frame_cnt = 0;
		end
	end

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_regs();
		logic [15:0] cmds [6];
		logic [31:0] v;
		cmds = '{host_link_pkg::cmd_joy0, host_link_pkg::cmd_joy1, host_link_pkg::cmd_joy2,
		         host_link_pkg::cmd_joy3, host_link_pkg::cmd_joy4, host_link_pkg::cmd_joy5};
		for (int i = 0; i < 6; i++) begin
			v = next_rand();
			tx_q = {cmds[i], v[15:0], v[31:16]};
			send_txn();
			check($sformatf("joystick_%0d", i), joy_out[i], v);
		end
		v = next_rand();
		tx_q = {host_link_pkg::cmd_status, v[15:0], v[31:16]};
		send_txn();
		check("status", status, v);
		v = next_rand();
		tx_q = {host_link_pkg::cmd_cfg, {8'h00, v[7:0]}};
		send_txn();
		check("buttons", buttons, v[1:0]);
		check("forced_scandoubler", forced_scandoubler, v[4]);
	endtask

	task automatic pulse_status(input logic [31:0] v);
		@(posedge clk_sys);
		status_in  <= v;
		status_set <= 1'b1;
		repeat (2) @(posedge clk_sys);
		status_set <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic test_readback();
		logic [31:0] v;
		tx_q = {host_link_pkg::cmd_conf_str, 16'h0, 16'h0, 16'h0, 16'h0};
		send_txn();
		// first payload word gives the most significant byte
		for (int n = 1; n <= conf_len; n++)
			check($sformatf("io_dout conf byte %0d", n), reply_q[n],
			      conf_str[8*conf_len-1-8*(n-1) -: 8]);
		pulse_status(next_rand());
		v = next_rand();
		pulse_status(v);
		tx_q = {host_link_pkg::cmd_status_req, 16'h0, 16'h0};
		send_txn();
		check("io_dout status req tag", reply_q[0], {8'h00, host_link_pkg::req_tag, 4'd2});
		check("io_dout status req low", reply_q[1], v[15:0]);
		check("io_dout status req high", reply_q[2], v[31:16]);
	endtask

	task automatic test_download();
		logic [7:0] idx;
		logic [7:0] bytes[$];
		idx = 8'(next_rand());
		tx_q = {host_link_pkg::cmd_file_index, {8'h00, idx}};
		send_txn();
		tx_q = {host_link_pkg::cmd_file_tx, 16'h0001};
		send_txn();
		check("ioctl_download", ioctl_download, 1'b1);
		wr_addr_q.delete();
		wr_data_q.delete();
		tx_q = {host_link_pkg::cmd_file_tx_dat};
		for (int i = 0; i < 6; i++) begin
			bytes.push_back(8'(next_rand()));
			tx_q.push_back({8'h00, bytes[i]});
		end
		send_txn();
		if (wr_addr_q.size() != bytes.size()) begin
			$display("download produced %0d writes instead of %0d",
			         wr_addr_q.size(), bytes.size());
			err_other++;
		end else begin
			foreach (bytes[i]) begin
				check("ioctl_addr", wr_addr_q[i], i);
				check("ioctl_dout", wr_data_q[i], bytes[i]);
			end
		end
		check("ioctl_index", ioctl_index, idx);
		tx_q = {host_link_pkg::cmd_file_tx, 16'h0000};
		send_txn();
		check("ioctl_download", ioctl_download, 1'b0);
		check("ioctl_addr final", ioctl_addr, bytes.size());
	endtask

	// sends kb_q as one keyboard transaction and checks the key event
	task automatic send_keys(input bit skip);
		logic [10:0] exp;
		logic [7:0]  prev;
		int          n;
		n    = kb_q.size();
		exp  = key_model;
		prev = (n >= 2) ? kb_q[n-2] : 8'h00;
		tx_q = {host_link_pkg::cmd_kbd};
		if (skip)
			tx_q.push_back(16'hFF00);
		foreach (kb_q[i]) begin
			tx_q.push_back({8'h00, kb_q[i]});
			exp_ps2.push_back(kb_q[i]);
		end
		if (!skip) begin
			exp[7:0]                     = kb_q[n-1];
			exp[ps2_pkg::key_pressed_bit] = prev != ps2_pkg::key_break;
			if (prev != ps2_pkg::key_break)
				exp[ps2_pkg::key_ext_bit] = prev == ps2_pkg::key_ext;
			else
				exp[ps2_pkg::key_ext_bit] = (n >= 3) && kb_q[n-3] == ps2_pkg::key_ext;
			exp[ps2_pkg::key_toggle_bit] = ~exp[ps2_pkg::key_toggle_bit];
		end
		send_txn();
		check("ps2_key", ps2_key, exp);
		key_model = exp;
	endtask

	task automatic test_keys();
		kb_q = {8'h1C};
		send_keys(1'b0);
		kb_q = {8'hF0, 8'h1C};
		send_keys(1'b0);
		kb_q = {8'hE0, 8'hF0, 8'h75};
		send_keys(1'b0);
		kb_q = {8'h29};
		send_keys(1'b1);
	endtask

	task automatic test_frames();
		int waited;
		waited = 0;
		while (frame_q.size() < exp_ps2.size() && waited < (1 << fifo_bits) * frame_clks) begin
			@(posedge clk_sys);
			waited++;
		end
		if (frame_q.size() != exp_ps2.size()) begin
			$display("PS/2 sent %0d frames, %0d bytes were queued",
			         frame_q.size(), exp_ps2.size());
			err_other++;
		end
		for (int i = 0; i < frame_q.size() && i < exp_ps2.size(); i++) begin
			check("ps2 start bit", frame_q[i][0], 1'b0);
			check("ps2 data", frame_q[i][8:1], exp_ps2[i]);
			check("ps2 parity", frame_q[i][9], ~^exp_ps2[i]);
			check("ps2 stop bit", frame_q[i][10], 1'b1);
		end
	endtask

	initial begin
		#(limit_clks * 10);
		$display("watchdog expired before the tests finished");
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		io_enable    = 1'b0;
		io_strobe    = 1'b0;
		io_din       = '0;
		status_in    = '0;
		status_set   = 1'b0;
		conf_str     = 32'h4D_69_53_54;
		rng          = 32'd26758;
		frame_cnt    = 0;
		frame_bits   = '0;
		key_model    = '0;
		err_mismatch = 0;
		err_other    = 0;
		@(posedge rst_n);
		repeat (2) @(posedge clk_sys);
		test_regs();
		test_readback();
		test_download();
		test_keys();
		test_frames();
		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
		         err_mismatch, err_other, dut_i.checker_i.fail_cnt);
		if (err_mismatch == 0 && err_other == 0 && dut_i.checker_i.fail_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end
endmodule

// File: test/hps_link_checker.sv
module hps_link_checker #(
	parameter int ps2_div = 3
) (
	input logic clk_sys,
	input logic rst_n,
	input logic ioctl_download,
	input logic ioctl_wr,
	input logic ps2_kbd_clk_out,
	input logic ps2_kbd_data_out
);
	timeunit 1ns;
	timeprecision 100ps;

	// clocks of a full idle gap on the PS/2 line
	localparam int idle_clks = 2 * ps2_div * ps2_pkg::ps2_idle_gap;

	logic        data_q;
	logic [15:0] idle_cnt;
	int          fail_cnt = 0;

	// counts cycles with the clock high and the data line still
	always_ff @(posedge clk_sys) begin
		data_q <= ps2_kbd_data_out;
		if (!rst_n || !ps2_kbd_clk_out || ps2_kbd_data_out != data_q)
			idle_cnt <= '0;
		else if (idle_cnt != 16'hFFFF)
			idle_cnt <= idle_cnt + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// rules on the top level ports
	////////////////////////////////////////////////////////////

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download)
		else begin
			$error("ioctl_wr high outside a download");
			fail_cnt++;
		end

	quiet_in_reset: assert property (@(posedge clk_sys)
		!rst_n |=> (!ioctl_download && !ioctl_wr))
		else begin
			$error("download outputs active during reset");
			fail_cnt++;
		end

	// the value that stayed still over the gap must be the idle level
	idle_line_high: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(idle_cnt >= 16'(idle_clks)) |-> data_q)
		else begin
			$error("PS/2 data low while the line is idle");
			fail_cnt++;
		end
endmodule

bind hps_link hps_link_checker #(
	.ps2_div(ps2_div)
) checker_i (
	.clk_sys         (clk_sys),
	.rst_n           (rst_n),
	.ioctl_download  (ioctl_download),
	.ioctl_wr        (ioctl_wr),
	.ps2_kbd_clk_out (ps2_kbd_clk_out),
	.ps2_kbd_data_out(ps2_kbd_data_out)
);

// File: test/clk_gen.sv
module clk_gen (
	output logic clk_sys,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// reset held low for 16 clocks
	initial begin
		rst_n = 1'b0;
		repeat (16) @(posedge clk_sys);
		rst_n <= 1'b1;
	end
endmodule

// File: hdl/hps_link.sv
module hps_link #(
	parameter int conf_len  = 4,
	parameter int ps2_div   = 2000,
	parameter int fifo_bits = 5
) (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      io_enable,
	input  logic                      io_strobe,
	input  logic [15:0]               io_din,
	output logic [15:0]               io_dout,
	input  logic [8*conf_len-1:0]     conf_str,
	output logic [31:0]               joystick_0,
	output logic [31:0]               joystick_1,
	output logic [31:0]               joystick_2,
	output logic [31:0]               joystick_3,
	output logic [31:0]               joystick_4,
	output logic [31:0]               joystick_5,
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output logic [31:0]               status,
	input  logic [31:0]               status_in,
	input  logic                      status_set,
	output logic                      ioctl_download,
	output logic [7:0]                ioctl_index,
	output logic                      ioctl_wr,
	output logic [24:0]               ioctl_addr,
	output logic [7:0]                ioctl_dout,
	output logic                      ps2_kbd_clk_out,
	output logic                      ps2_kbd_data_out,
	output logic [ps2_pkg::key_w-1:0] ps2_key
);

	logic [15:0]                           cmd;
	logic [host_link_pkg::word_cnt_w-1:0] word_idx;
	logic                                  word_stb;
	host_link_pkg::host_word_t            word;
	logic                                  txn_end;
	logic [7:0]                            kbd_byte;
	logic                                  kbd_we;

	////////////////////////////////////////////////////////////
	// input side
	////////////////////////////////////////////////////////////

	host_frame frame_i (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.io_enable(io_enable),
		.io_strobe(io_strobe),
		.io_din   (io_din),
		.cmd      (cmd),
		.word_idx (word_idx),
		.word_stb (word_stb),
		.word     (word),
		.txn_end  (txn_end)
	);

	// register bank and replies
	host_regs #(
		.conf_len(conf_len)
	) regs_i (
		.clk_sys           (clk_sys),
		.rst_n             (rst_n),
		.cmd               (cmd),
		.word_idx          (word_idx),
		.word_stb          (word_stb),
		.word              (word),
		.txn_end           (txn_end),
		.io_strobe         (io_strobe),
		.io_din            (io_din),
		.conf_str          (conf_str),
		.status_in         (status_in),
		.status_set        (status_set),
		.io_dout           (io_dout),
		.joystick_0        (joystick_0),
		.joystick_1        (joystick_1),
		.joystick_2        (joystick_2),
		.joystick_3        (joystick_3),
		.joystick_4        (joystick_4),
		.joystick_5        (joystick_5),
		.status            (status),
		.buttons           (buttons),
		.forced_scandoubler(forced_scandoubler),
		.ps2_key           (ps2_key),
		.kbd_byte          (kbd_byte),
		.kbd_we            (kbd_we)
	);

	file_loader loader_i (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.cmd           (cmd),
		.word_stb      (word_stb),
		.word          (word),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout)
	);

	////////////////////////////////////////////////////////////
	// output side
	////////////////////////////////////////////////////////////

	ps2_kbd_tx #(
		.ps2_div  (ps2_div),
		.fifo_bits(fifo_bits)
	) kbd_tx_i (
		.clk_sys         (clk_sys),
		.rst_n           (rst_n),
		.kbd_byte        (kbd_byte),
		.kbd_we          (kbd_we),
		.ps2_kbd_clk_out (ps2_kbd_clk_out),
		.ps2_kbd_data_out(ps2_kbd_data_out)
	);

endmodule

// File: hdl/ps2_kbd_tx.sv
module ps2_kbd_tx #(
	parameter int ps2_div   = 2000,
	parameter int fifo_bits = 5
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic [7:0] kbd_byte,
	input  logic       kbd_we,
	output logic       ps2_kbd_clk_out,
	output logic       ps2_kbd_data_out
);

	localparam int div_w = $clog2(ps2_div + 1);
	localparam int gap_w = $clog2(ps2_pkg::ps2_idle_gap + 1);
	localparam int bit_w = $clog2(ps2_pkg::ps2_frame_bits + 1);

	logic [7:0]         fifo_mem [1 << fifo_bits];
	logic [fifo_bits:0] wr_ptr;
	logic [fifo_bits:0] rd_ptr;
	logic               fifo_empty;
	logic               fifo_full;
	logic [div_w-1:0]   div_cnt;
	logic               ps2_clk;
	logic               tick;
	logic               rise;
	logic               fall;
	logic [gap_w-1:0]   gap_cnt;
	logic [bit_w-1:0]   bit_cnt;
	logic [7:0]         shift;
	logic               parity;

	assign fifo_empty = wr_ptr == rd_ptr;
	assign fifo_full  = (wr_ptr[fifo_bits] != rd_ptr[fifo_bits]) &&
	                    (wr_ptr[fifo_bits-1:0] == rd_ptr[fifo_bits-1:0]);

	assign tick = div_cnt == div_w'(ps2_div - 1);
	assign rise = tick & ~ps2_clk;
	assign fall = tick & ps2_clk;

	////////////////////////////////////////////////////////////
	// byte queue, new bytes dropped when full
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (kbd_we && !fifo_full)
			fifo_mem[wr_ptr[fifo_bits-1:0]] <= kbd_byte;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			wr_ptr <= '0;
		else if (kbd_we && !fifo_full)
			wr_ptr <= wr_ptr + 1'b1;
	end

	// half period divider
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_cnt <= '0;
			ps2_clk <= 1'b0;
		end else if (tick) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// frame sender, data moves on the rising PS/2 clock
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_ptr           <= '0;
			gap_cnt          <= '0;
			bit_cnt          <= '0;
			ps2_kbd_clk_out  <= 1'b1;
			ps2_kbd_data_out <= 1'b1;
		end else begin
			if (rise) begin
				ps2_kbd_clk_out <= 1'b1;
				if (bit_cnt == '0) begin
					if (gap_cnt != gap_w'(ps2_pkg::ps2_idle_gap)) begin
						gap_cnt <= gap_cnt + 1'b1;
					end else if (!fifo_empty) begin
						// start bit
						gap_cnt          <= '0;
						rd_ptr           <= rd_ptr + 1'b1;
						bit_cnt          <= bit_w'(1);
						ps2_kbd_data_out <= 1'b0;
					end
				end else if (bit_cnt <= 8) begin
					ps2_kbd_data_out <= shift[0];
					bit_cnt          <= bit_cnt + 1'b1;
				end else if (bit_cnt == 9) begin
					ps2_kbd_data_out <= parity;
					bit_cnt          <= bit_cnt + 1'b1;
				end else if (bit_cnt == 10) begin
					ps2_kbd_data_out <= 1'b1;
					bit_cnt          <= bit_cnt + 1'b1;
				end else if (bit_cnt == bit_w'(ps2_pkg::ps2_frame_bits)) begin
					bit_cnt <= '0;
				end
			end
			// clock pulses low only inside a frame
			if (fall)
				ps2_kbd_clk_out <= bit_cnt == '0;
		end
	end

	// data shifter and odd parity
	always_ff @(posedge clk_sys) begin
		if (rise && bit_cnt == '0 && !fifo_empty) begin
			shift  <= fifo_mem[rd_ptr[fifo_bits-1:0]];
			parity <= 1'b1;
		end else if (rise && bit_cnt >= 1 && bit_cnt <= 8) begin
			shift  <= {1'b0, shift[7:1]};
			parity <= parity ^ shift[0];
		end
	end

endmodule

// File: hdl/file_loader.sv
module file_loader (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic [15:0]                cmd,
	input  logic                       word_stb,
	input  host_link_pkg::host_word_t word,
	output logic                       ioctl_download,
	output logic [7:0]                 ioctl_index,
	output logic                       ioctl_wr,
	output logic [24:0]                ioctl_addr,
	output logic [7:0]                 ioctl_dout
);

	// next write address, counts bytes of the running download
	logic [24:0] addr;

	// cmd is still zero while its own word is strobed,
	// so every match below is a payload word
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			addr           <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (word_stb) begin
				case (cmd)
					host_link_pkg::cmd_file_index:
						ioctl_index <= word.full[7:0];
					host_link_pkg::cmd_file_tx:
						if (|word.full[7:0]) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// publish the byte count
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					host_link_pkg::cmd_file_tx_dat: begin
						ioctl_addr <= addr;
						ioctl_wr   <= 1'b1;
						addr       <= addr + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (word_stb && cmd == host_link_pkg::cmd_file_tx_dat)
			ioctl_dout <= word.full[7:0];
	end

endmodule

// File: hdl/host_regs.sv
module host_regs #(
	parameter int conf_len = 4
) (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic [15:0]                           cmd,
	input  logic [host_link_pkg::word_cnt_w-1:0] word_idx,
	input  logic                                  word_stb,
	input  host_link_pkg::host_word_t            word,
	input  logic                                  txn_end,
	input  logic                                  io_strobe,
	input  logic [15:0]                           io_din,
	input  logic [8*conf_len-1:0]                 conf_str,
	input  logic [31:0]                           status_in,
	input  logic                                  status_set,
	output logic [15:0]                           io_dout,
	output logic [31:0]                           joystick_0,
	output logic [31:0]                           joystick_1,
	output logic [31:0]                           joystick_2,
	output logic [31:0]                           joystick_3,
	output logic [31:0]                           joystick_4,
	output logic [31:0]                           joystick_5,
	output logic [31:0]                           status,
	output logic [1:0]                            buttons,
	output logic                                  forced_scandoubler,
	output logic [ps2_pkg::key_w-1:0]             ps2_key,
	output logic [7:0]                            kbd_byte,
	output logic                                  kbd_we
);

	logic [31:0] joy [6];
	logic [2:0]  joy_sel;
	logic        joy_hit;
	logic        payload;
	logic        cmd_word;
	logic        skip_word;
	logic [31:0] kbd_raw;
	logic        kbd_skip;
	logic        pressed;
	logic        extended;
	logic        status_set_q;
	logic [3:0]  req_cnt;
	logic [31:0] status_req;
	logic [15:0] reply;

	assign cmd_word  = word_stb && (word_idx == '0);
	assign payload   = word_stb && (word_idx != '0);
	assign skip_word = &word.kbd.flag;

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];
	assign joystick_4 = joy[4];
	assign joystick_5 = joy[5];

	// released keys carry the break byte before the code
	assign pressed  = kbd_raw[15:8] != ps2_pkg::key_break;
	assign extended = pressed ? (kbd_raw[15:8] == ps2_pkg::key_ext)
	                          : (kbd_raw[23:16] == ps2_pkg::key_ext);

	always_comb begin
		joy_hit = 1'b1;
		joy_sel = 3'd0;
		case (cmd)
			host_link_pkg::cmd_joy0: joy_sel = 3'd0;
			host_link_pkg::cmd_joy1: joy_sel = 3'd1;
			host_link_pkg::cmd_joy2: joy_sel = 3'd2;
			host_link_pkg::cmd_joy3: joy_sel = 3'd3;
			host_link_pkg::cmd_joy4: joy_sel = 3'd4;
			host_link_pkg::cmd_joy5: joy_sel = 3'd5;
			default: joy_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// register writes, low half of a 32-bit value comes first
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int i = 0; i < 6; i++)
				joy[i] <= '0;
			status             <= '0;
			buttons            <= '0;
			forced_scandoubler <= 1'b0;
		end else if (payload) begin
			if (joy_hit && word_idx == 1)
				joy[joy_sel][15:0] <= word.full;
			if (joy_hit && word_idx == 2)
				joy[joy_sel][31:16] <= word.full;
			if (cmd == host_link_pkg::cmd_status && word_idx == 1)
				status[15:0] <= word.full;
			if (cmd == host_link_pkg::cmd_status && word_idx == 2)
				status[31:16] <= word.full;
			if (cmd == host_link_pkg::cmd_cfg) begin
				buttons            <= word.full[1:0];
				forced_scandoubler <= word.full[4];
			end
		end
	end

	// core side status request
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_set_q <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q)
				req_cnt <= req_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q)
			status_req <= status_in;
	end

	////////////////////////////////////////////////////////////
	// read replies
	////////////////////////////////////////////////////////////

	always_comb begin
		reply = '0;
		if (cmd_word && io_din == host_link_pkg::cmd_status_req)
			reply = {8'h00, host_link_pkg::req_tag, req_cnt};
		if (payload) begin
			case (cmd)
				host_link_pkg::cmd_conf_str:
					if (int'(word_idx) <= conf_len)
						reply[7:0] = conf_str[(conf_len - int'(word_idx)) * 8 +: 8];
				host_link_pkg::cmd_status_req:
					if (word_idx == 1)
						reply = status_req[15:0];
					else if (word_idx == 2)
						reply = status_req[31:16];
				default: reply = '0;
			endcase
		end
	end

	// reply holds until the next strobe
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			io_dout <= '0;
		else if (io_strobe)
			io_dout <= reply;
	end

	////////////////////////////////////////////////////////////
	// keyboard words
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			kbd_skip <= 1'b0;
			kbd_we   <= 1'b0;
			ps2_key  <= '0;
		end else begin
			kbd_we <= payload && cmd == host_link_pkg::cmd_kbd && !skip_word;
			if (payload && cmd == host_link_pkg::cmd_kbd && skip_word)
				kbd_skip <= 1'b1;
			if (txn_end) begin
				kbd_skip <= 1'b0;
				if (cmd == host_link_pkg::cmd_kbd && !kbd_skip) begin
					ps2_key[7:0]                     <= kbd_raw[7:0];
					ps2_key[ps2_pkg::key_ext_bit]     <= extended;
					ps2_key[ps2_pkg::key_pressed_bit] <= pressed;
					ps2_key[ps2_pkg::key_toggle_bit]  <= ~ps2_key[ps2_pkg::key_toggle_bit];
				end
			end
		end
	end

	// raw byte history, newest byte in the low end
	always_ff @(posedge clk_sys) begin
		if (cmd_word && io_din == host_link_pkg::cmd_kbd)
			kbd_raw <= '0;
		else if (payload && cmd == host_link_pkg::cmd_kbd && !skip_word && !kbd_skip)
			kbd_raw <= {kbd_raw[23:0], word.kbd.data};
		if (payload && cmd == host_link_pkg::cmd_kbd && !skip_word)
			kbd_byte <= word.kbd.data;
	end

endmodule

// File: hdl/host_frame.sv
module host_frame (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic                                  io_enable,
	input  logic                                  io_strobe,
	input  logic [15:0]                           io_din,
	output logic [15:0]                           cmd,
	output logic [host_link_pkg::word_cnt_w-1:0] word_idx,
	output logic                                  word_stb,
	output host_link_pkg::host_word_t            word,
	output logic                                  txn_end
);

	logic enable_q;

	// a word counts only inside a transaction
	assign word_stb  = io_enable & io_strobe;
	assign word.full = io_din;

	// first low cycle after the transaction, cmd is still valid here
	assign txn_end = enable_q & ~io_enable;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			enable_q <= 1'b0;
			cmd      <= '0;
			word_idx <= '0;
		end else begin
			enable_q <= io_enable;
			if (!io_enable) begin
				cmd      <= '0;
				word_idx <= '0;
			end else if (io_strobe) begin
				// word 0 is the command, payload numbered from 1
				if (word_idx == '0)
					cmd <= io_din;
				if (!(&word_idx))
					word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

// File: hdl/ps2_pkg.sv
package ps2_pkg;

	// start, 8 data bits, parity, stop
	localparam int ps2_frame_bits = 11;

	// idle PS/2 clock periods before a frame may start
	localparam int ps2_idle_gap = 4;

	// scan code prefixes
	localparam logic [7:0] key_break = 8'hF0;
	localparam logic [7:0] key_ext   = 8'hE0;

	////////////////////////////////////////////////////////////
	// key event word, scan code sits in bits 7..0
	////////////////////////////////////////////////////////////

	localparam int key_w           = 11;
	localparam int key_ext_bit     = 8;
	localparam int key_pressed_bit = 9;
	localparam int key_toggle_bit  = 10;

endpackage

// File: hdl/host_link_pkg.sv
package host_link_pkg;

	// payload counter width, the count saturates at all ones
	localparam int word_cnt_w = 10;

	// one bus word, read whole or as a keyboard flag/data pair
	typedef union packed {
		logic [15:0] full;
		struct packed {
			logic [7:0] flag;
			logic [7:0] data;
		} kbd;
	} host_word_t;

	////////////////////////////////////////////////////////////
	// command codes, first word of each transaction
	////////////////////////////////////////////////////////////

	localparam logic [15:0] cmd_cfg         = 16'h0001;
	localparam logic [15:0] cmd_joy0        = 16'h0002;
	localparam logic [15:0] cmd_joy1        = 16'h0003;
	localparam logic [15:0] cmd_kbd         = 16'h0005;
	localparam logic [15:0] cmd_joy2        = 16'h0010;
	localparam logic [15:0] cmd_joy3        = 16'h0011;
	localparam logic [15:0] cmd_joy4        = 16'h0012;
	localparam logic [15:0] cmd_joy5        = 16'h0013;
	localparam logic [15:0] cmd_conf_str    = 16'h0014;
	localparam logic [15:0] cmd_status      = 16'h001E;
	localparam logic [15:0] cmd_status_req  = 16'h0029;
	localparam logic [15:0] cmd_file_tx     = 16'h0053;
	localparam logic [15:0] cmd_file_tx_dat = 16'h0054;
	localparam logic [15:0] cmd_file_index  = 16'h0055;

	// upper nibble of the status request reply, above the count
	localparam logic [3:0] req_tag = 4'hA;

endpackage
